/* list.f */
+incdir+logic
logic/core_types_pkg.sv
logic/core_isa_pkg.sv
logic/core_fetch.sv
logic/core_decode.sv
logic/core_exec.sv
logic/core_writeback.sv
logic/core_top.sv
tb/core_clkgen.sv
tb/core_properties.sv
tb/core_tb.sv

/* logic/core_decode.sv */
/*
 * Decode stage: field extraction, ALU and control-flow decode
 * Operand select with forwarding from execute, stage-2 register
 */
`timescale 1ns/1ps
`default_nettype none

module core_decode
    import core_types_pkg::*, core_isa_pkg::*;
(
    input  wire             g_clk,
    input  wire             i_rst_n,
    input  wire             i_s1_valid,
    input  wire xlen_t      i_s1_pc,
    input  wire instr_t     i_s1_instr,
    output reg_addr_t       o_rs1_addr,  // To register file
    output reg_addr_t       o_rs2_addr,
    input  wire xlen_t      i_rs1_data,  // Includes writeback bypass
    input  wire xlen_t      i_rs2_data,
    input  wire             i_ex_valid,  // Instruction now in execute
    input  wire reg_addr_t  i_ex_rd,     // Zero when it writes nothing
    input  wire xlen_t      i_ex_result,
    output logic            o_s2_valid,
    output xlen_t           o_s2_pc,
    output reg_addr_t       o_s2_rd,
    output xlen_t           o_s2_lhs,
    output xlen_t           o_s2_rhs,
    output xlen_t           o_s2_imm,
    output alu_op_t         o_s2_alu_op,
    output cfu_op_t         o_s2_cfu_op,
    output instr_t          o_s2_instr
);

opcode_t    opcode;
logic [2:0] funct3;
logic       alt;                         // instr[30], SUB and SRA select
logic       is_op;
logic       is_alu;                      // OP or OP_IMM
xlen_t      imm_i;
xlen_t      imm_u;
xlen_t      imm_j;
xlen_t      imm_b;
xlen_t      imm;
alu_op_t    alu_op;
cfu_op_t    cfu_op;
logic       fwd_rs1;
logic       fwd_rs2;
xlen_t      rs1_val;
xlen_t      rs2_val;

assign opcode     = i_s1_instr[6:0];
assign funct3     = i_s1_instr[14:12];
assign alt        = i_s1_instr[30];
assign is_op      = (opcode == OPC_OP);
assign is_alu     = is_op || (opcode == OPC_OP_IMM);
assign o_rs1_addr = i_s1_instr[19:15];
assign o_rs2_addr = i_s1_instr[24:20];

// Immediates
// --------------------
assign imm_i = {{20{i_s1_instr[31]}}, i_s1_instr[31:20]};
assign imm_u = {i_s1_instr[31:12], 12'b0};
assign imm_j = {{12{i_s1_instr[31]}}, i_s1_instr[19:12], i_s1_instr[20],
                i_s1_instr[30:21], 1'b0};
assign imm_b = {{20{i_s1_instr[31]}}, i_s1_instr[7], i_s1_instr[30:25],
                i_s1_instr[11:8], 1'b0};

always_comb begin
    case (opcode)
        OPC_LUI:    imm = imm_u;
        OPC_JAL:    imm = imm_j;
        OPC_BRANCH: imm = imm_b;
        default:    imm = imm_i;         // OP_IMM, unused elsewhere
    endcase
end

// Operation decode
// --------------------
always_comb begin
    alu_op = '0;                         // Unknown opcodes write nothing
    if (is_alu) begin
        case (funct3)
            3'b000: alu_op[(alt && is_op) ? ALU_SUB : ALU_ADD] = 1'b1; // No SUBI
            3'b001: alu_op[ALU_SLL]  = 1'b1;
            3'b010: alu_op[ALU_SLT]  = 1'b1;
            3'b011: alu_op[ALU_SLTU] = 1'b1;
            3'b100: alu_op[ALU_XOR]  = 1'b1;
            3'b101: alu_op[alt ? ALU_SRA : ALU_SRL] = 1'b1;
            3'b110: alu_op[ALU_OR]   = 1'b1;
            3'b111: alu_op[ALU_AND]  = 1'b1;
        endcase
    end
    if (opcode == OPC_LUI) begin
        alu_op[ALU_ADD] = 1'b1;          // Zero plus upper immediate
    end
end

assign cfu_op = (opcode == OPC_JAL)                          ? CFU_JAL :
                (opcode == OPC_BRANCH && funct3 == 3'b000)   ? CFU_BEQ :
                (opcode == OPC_BRANCH && funct3 == 3'b001)   ? CFU_BNE : CFU_NONE;

// Forwarding from execute, writeback already bypassed in the register file
assign fwd_rs1 = i_ex_valid && (i_ex_rd != '0) && (i_ex_rd == o_rs1_addr);
assign fwd_rs2 = i_ex_valid && (i_ex_rd != '0) && (i_ex_rd == o_rs2_addr);
assign rs1_val = fwd_rs1 ? i_ex_result : i_rs1_data;
assign rs2_val = fwd_rs2 ? i_ex_result : i_rs2_data;

// Stage-2 register
// --------------------
always_ff @(posedge g_clk) begin
    if (!i_rst_n) begin
        o_s2_valid <= 1'b0;
    end else begin
        o_s2_valid <= i_s1_valid;
    end
end

always_ff @(posedge g_clk) begin
    o_s2_pc     <= i_s1_pc;
    o_s2_rd     <= i_s1_instr[11:7];
    o_s2_lhs    <= (opcode == OPC_LUI) ? '0 : rs1_val;
    o_s2_rhs    <= (is_op || opcode == OPC_BRANCH) ? rs2_val : imm; // Branches compare regs
    o_s2_imm    <= imm;
    o_s2_alu_op <= alu_op;
    o_s2_cfu_op <= cfu_op;
    o_s2_instr  <= i_s1_instr;
end

endmodule

`default_nettype wire

/* logic/core_exec.sv */
/*
 * Execute stage: ALU, BEQ/BNE/JAL resolution and redirect
 * Stage-3 register
 */
`timescale 1ns/1ps
`default_nettype none

module core_exec
    import core_types_pkg::*, core_isa_pkg::*;
(
    input  wire             g_clk,
    input  wire             i_rst_n,
    input  wire             i_s2_valid,
    input  wire xlen_t      i_s2_pc,
    input  wire reg_addr_t  i_s2_rd,
    input  wire xlen_t      i_s2_lhs,
    input  wire xlen_t      i_s2_rhs,
    input  wire xlen_t      i_s2_imm,
    input  wire alu_op_t    i_s2_alu_op,
    input  wire cfu_op_t    i_s2_cfu_op,
    input  wire instr_t     i_s2_instr,
    output logic            o_ex_valid,  // Forwarding source for decode
    output reg_addr_t       o_ex_rd,
    output xlen_t           o_ex_result,
    output logic            o_cf_valid,  // Taken branch or JAL
    output xlen_t           o_cf_target,
    output logic            o_s3_valid,
    output xlen_t           o_s3_pc,
    output instr_t          o_s3_instr,
    output reg_addr_t       o_s3_rd,
    output xlen_t           o_s3_wdata
);

logic [4:0] shamt;
xlen_t      alu_res;
logic       eq;
logic       taken;
logic       writes;                      // ALU op or JAL link

assign shamt = i_s2_rhs[4:0];

// ALU
// --------------------
always_comb begin
    case (1'b1)
        i_s2_alu_op[ALU_ADD]:  alu_res = i_s2_lhs + i_s2_rhs;
        i_s2_alu_op[ALU_SUB]:  alu_res = i_s2_lhs - i_s2_rhs;
        i_s2_alu_op[ALU_AND]:  alu_res = i_s2_lhs & i_s2_rhs;
        i_s2_alu_op[ALU_OR]:   alu_res = i_s2_lhs | i_s2_rhs;
        i_s2_alu_op[ALU_XOR]:  alu_res = i_s2_lhs ^ i_s2_rhs;
        i_s2_alu_op[ALU_SLL]:  alu_res = i_s2_lhs << shamt;
        i_s2_alu_op[ALU_SRL]:  alu_res = i_s2_lhs >> shamt;
        i_s2_alu_op[ALU_SRA]:  alu_res = xlen_t'($signed(i_s2_lhs) >>> shamt);
        i_s2_alu_op[ALU_SLT]:  alu_res = xlen_t'($signed(i_s2_lhs) < $signed(i_s2_rhs));
        i_s2_alu_op[ALU_SLTU]: alu_res = xlen_t'(i_s2_lhs < i_s2_rhs);
        default:               alu_res = '0;
    endcase
end

// Branch resolution
// --------------------
assign eq = (i_s2_lhs == i_s2_rhs);

always_comb begin
    case (i_s2_cfu_op)
        CFU_JAL: taken = 1'b1;
        CFU_BEQ: taken = eq;
        CFU_BNE: taken = !eq;
        default: taken = 1'b0;
    endcase
end

assign o_cf_valid  = i_s2_valid && taken;  // Next s2 is a bubble, so one cycle
assign o_cf_target = i_s2_pc + i_s2_imm;

// Branches and unsupported opcodes retire with rd zero
assign writes      = (i_s2_alu_op != '0) || (i_s2_cfu_op == CFU_JAL);
assign o_ex_valid  = i_s2_valid;
assign o_ex_rd     = writes ? i_s2_rd : '0;
assign o_ex_result = (i_s2_cfu_op == CFU_JAL) ? i_s2_pc + xlen_t'(4) : alu_res;

// Stage-3 register
// --------------------
always_ff @(posedge g_clk) begin
    if (!i_rst_n) begin
        o_s3_valid <= 1'b0;
    end else begin
        o_s3_valid <= i_s2_valid;
    end
end

always_ff @(posedge g_clk) begin
    o_s3_pc    <= i_s2_pc;
    o_s3_instr <= i_s2_instr;
    o_s3_rd    <= o_ex_rd;
    o_s3_wdata <= o_ex_result;
end

endmodule

`default_nettype wire

/* logic/core_fetch.sv */
/*
 * Fetch stage: PC register and instruction bus requests
 * Redirects from execute, stale response drop
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core_fetch
    import core_types_pkg::*;
(
    input  wire          g_clk,
    input  wire          i_rst_n,        // Sync, active low
    input  wire          i_cf_valid,     // Redirect pulse from execute
    input  wire xlen_t   i_cf_target,    // Redirect destination
    output logic         o_imem_req,     // Held until granted
    output xlen_t        o_imem_addr,    // Stable while request pending
    input  wire          i_imem_gnt,     // Grant with data, same cycle
    input  wire instr_t  i_imem_rdata,
    output logic         o_s1_valid,     // Instruction handed to decode
    output xlen_t        o_s1_pc,
    output instr_t       o_s1_instr
);

fetch_state_e state_q;
fetch_state_e state_d;
xlen_t        pc_q;                      // Address of the pending request
xlen_t        pc_d;
xlen_t        drop_tgt_q;                // Target waiting behind a stale fetch
logic         req_q;
logic         fire;                      // Request granted this cycle

assign fire        = req_q && i_imem_gnt;
assign o_imem_req  = req_q;
assign o_imem_addr = pc_q;

// Wrong-path word in the redirect cycle and stale words are never passed on
assign o_s1_valid  = fire && (state_q == FETCH_RUN) && !i_cf_valid;
assign o_s1_pc     = pc_q;
assign o_s1_instr  = i_imem_rdata;

// Next PC and state
// --------------------
always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    case (state_q)
        FETCH_RUN: begin
            if (i_cf_valid && !fire) begin
                state_d = FETCH_DROP;    // Bus rule keeps the old address up
            end else if (i_cf_valid) begin
                pc_d = i_cf_target;      // Granted now, target next cycle
            end else if (fire) begin
                pc_d = pc_q + xlen_t'(4);
            end
        end
        FETCH_DROP: begin
            if (fire) begin
                state_d = FETCH_RUN;     // Stale word gone
                pc_d    = drop_tgt_q;
            end
        end
        default: state_d = FETCH_RUN;
    endcase
end

always_ff @(posedge g_clk) begin
    if (!i_rst_n) begin
        req_q   <= 1'b0;
        state_q <= FETCH_RUN;
        pc_q    <= `CORE_PC_RESET;
    end else begin
        req_q   <= 1'b1;                 // Always fetching once out of reset
        state_q <= state_d;
        pc_q    <= pc_d;
    end
end

// Only read in FETCH_DROP, which is entered on the same pulse
always_ff @(posedge g_clk) begin
    if (i_cf_valid) begin
        drop_tgt_q <= i_cf_target;
    end
end

endmodule

`default_nettype wire

/* logic/core_isa_pkg.sv */
/*
 * RV32I major opcodes used by the core
 * One-hot ALU operation and control-flow codes
 */
`default_nettype none

package core_isa_pkg;

    // Major opcodes
    // --------------------
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_OP     = 7'b0110011;     // Register-register ALU
    localparam opcode_t OPC_OP_IMM = 7'b0010011;     // Register-immediate ALU
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // ALU operation, one bit per op
    // --------------------
    typedef logic [9:0] alu_op_t;

    localparam int unsigned ALU_ADD  = 0;
    localparam int unsigned ALU_SUB  = 1;
    localparam int unsigned ALU_AND  = 2;
    localparam int unsigned ALU_OR   = 3;
    localparam int unsigned ALU_XOR  = 4;
    localparam int unsigned ALU_SLL  = 5;
    localparam int unsigned ALU_SRL  = 6;
    localparam int unsigned ALU_SRA  = 7;
    localparam int unsigned ALU_SLT  = 8;
    localparam int unsigned ALU_SLTU = 9;

    // Control-flow operation
    // --------------------
    typedef logic [1:0] cfu_op_t;

    localparam cfu_op_t CFU_NONE = 2'd0;             // Falls through
    localparam cfu_op_t CFU_JAL  = 2'd1;             // Always taken, writes link
    localparam cfu_op_t CFU_BEQ  = 2'd2;
    localparam cfu_op_t CFU_BNE  = 2'd3;

endpackage

`default_nettype wire

/* logic/core_params.svh */
/*
 * Core widths, register file size and reset PC
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and address width
`define CORE_XLEN        32

// Register index width
`define CORE_REG_ADDR_W  5

// General registers, x0 included
`define CORE_NREGS       32

// First fetch address after reset
`define CORE_PC_RESET    32'h0000_1000

`endif

/* logic/core_top.sv */
/*
 * Three-stage RV32I core, top level
 * Fetch/decode, execute and writeback wiring
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core_top
    import core_types_pkg::*, core_isa_pkg::*;
(
    input  wire                          g_clk,
    input  wire                          i_rst_n,      // Sync, active low
    output logic                         o_imem_req,
    output logic [`CORE_XLEN-1:0]        o_imem_addr,
    input  wire                          i_imem_gnt,
    input  wire instr_t                  i_imem_rdata,
    output logic                         o_trs_valid,  // Retirement trace
    output logic [`CORE_XLEN-1:0]        o_trs_pc,
    output instr_t                       o_trs_instr,
    output logic [`CORE_REG_ADDR_W-1:0]  o_trs_rd,
    output logic [`CORE_XLEN-1:0]        o_trs_wdata
);

// Pipeline wiring
// --------------------
logic      cf_valid;                     // Redirect pulse
xlen_t     cf_target;

logic      s1_valid;
xlen_t     s1_pc;
instr_t    s1_instr;

reg_addr_t rs1_addr;
reg_addr_t rs2_addr;
xlen_t     rs1_data;
xlen_t     rs2_data;

logic      ex_valid;                     // Execute forwarding path
reg_addr_t ex_rd;
xlen_t     ex_result;

logic      s2_valid;
xlen_t     s2_pc;
reg_addr_t s2_rd;
xlen_t     s2_lhs;
xlen_t     s2_rhs;
xlen_t     s2_imm;
alu_op_t   s2_alu_op;
cfu_op_t   s2_cfu_op;
instr_t    s2_instr;

logic      s3_valid;
xlen_t     s3_pc;
instr_t    s3_instr;
reg_addr_t s3_rd;
xlen_t     s3_wdata;

core_fetch u_core_fetch (
    .g_clk        (g_clk),
    .i_rst_n      (i_rst_n),
    .i_cf_valid   (cf_valid),
    .i_cf_target  (cf_target),
    .o_imem_req   (o_imem_req),
    .o_imem_addr  (o_imem_addr),
    .i_imem_gnt   (i_imem_gnt),
    .i_imem_rdata (i_imem_rdata),
    .o_s1_valid   (s1_valid),
    .o_s1_pc      (s1_pc),
    .o_s1_instr   (s1_instr)
);

core_decode u_core_decode (
    .g_clk        (g_clk),
    .i_rst_n      (i_rst_n),
    .i_s1_valid   (s1_valid),
    .i_s1_pc      (s1_pc),
    .i_s1_instr   (s1_instr),
    .o_rs1_addr   (rs1_addr),
    .o_rs2_addr   (rs2_addr),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_ex_valid   (ex_valid),
    .i_ex_rd      (ex_rd),
    .i_ex_result  (ex_result),
    .o_s2_valid   (s2_valid),
    .o_s2_pc      (s2_pc),
    .o_s2_rd      (s2_rd),
    .o_s2_lhs     (s2_lhs),
    .o_s2_rhs     (s2_rhs),
    .o_s2_imm     (s2_imm),
    .o_s2_alu_op  (s2_alu_op),
    .o_s2_cfu_op  (s2_cfu_op),
    .o_s2_instr   (s2_instr)
);

core_exec u_core_exec (
    .g_clk        (g_clk),
    .i_rst_n      (i_rst_n),
    .i_s2_valid   (s2_valid),
    .i_s2_pc      (s2_pc),
    .i_s2_rd      (s2_rd),
    .i_s2_lhs     (s2_lhs),
    .i_s2_rhs     (s2_rhs),
    .i_s2_imm     (s2_imm),
    .i_s2_alu_op  (s2_alu_op),
    .i_s2_cfu_op  (s2_cfu_op),
    .i_s2_instr   (s2_instr),
    .o_ex_valid   (ex_valid),
    .o_ex_rd      (ex_rd),
    .o_ex_result  (ex_result),
    .o_cf_valid   (cf_valid),
    .o_cf_target  (cf_target),
    .o_s3_valid   (s3_valid),
    .o_s3_pc      (s3_pc),
    .o_s3_instr   (s3_instr),
    .o_s3_rd      (s3_rd),
    .o_s3_wdata   (s3_wdata)
);

core_writeback u_core_writeback (
    .g_clk        (g_clk),
    .i_rst_n      (i_rst_n),
    .i_rs1_addr   (rs1_addr),
    .i_rs2_addr   (rs2_addr),
    .o_rs1_data   (rs1_data),
    .o_rs2_data   (rs2_data),
    .i_s3_valid   (s3_valid),
    .i_s3_pc      (s3_pc),
    .i_s3_instr   (s3_instr),
    .i_s3_rd      (s3_rd),
    .i_s3_wdata   (s3_wdata),
    .o_trs_valid  (o_trs_valid),
    .o_trs_pc     (o_trs_pc),
    .o_trs_instr  (o_trs_instr),
    .o_trs_rd     (o_trs_rd),
    .o_trs_wdata  (o_trs_wdata)
);

endmodule

`default_nettype wire

/* logic/core_types_pkg.sv */
/*
 * Data path vector types
 * Fetch FSM state encoding
 */
`default_nettype none

`include "core_params.svh"

package core_types_pkg;

    // Data path words
    // --------------------
    typedef logic [`CORE_XLEN-1:0]       xlen_t;     // Data or address word
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t; // x0 .. x31
    typedef logic [31:0]                 instr_t;    // No compressed forms

    // Fetch FSM
    // --------------------
    typedef enum logic [1:0] {
        FETCH_RUN  = 2'd0,                           // Normal sequential fetch
        FETCH_DROP = 2'd1                            // Stale response outstanding
    } fetch_state_e;

endpackage

`default_nettype wire

/* logic/core_writeback.sv */
/*
 * Writeback stage: register file, two reads and one write
 * Write-through bypass on reads, retirement trace
 */
`timescale 1ns/1ps
`default_nettype none

module core_writeback
    import core_types_pkg::*;
(
    input  wire             g_clk,
    input  wire             i_rst_n,
    input  wire reg_addr_t  i_rs1_addr,
    input  wire reg_addr_t  i_rs2_addr,
    output xlen_t           o_rs1_data,
    output xlen_t           o_rs2_data,
    input  wire             i_s3_valid,
    input  wire xlen_t      i_s3_pc,
    input  wire instr_t     i_s3_instr,
    input  wire reg_addr_t  i_s3_rd,     // Zero for no write
    input  wire xlen_t      i_s3_wdata,
    output logic            o_trs_valid, // One pulse per retirement
    output xlen_t           o_trs_pc,
    output instr_t          o_trs_instr,
    output reg_addr_t       o_trs_rd,
    output xlen_t           o_trs_wdata
);

// x1 .. x31, x0 has no storage
xlen_t regs_q [1:(1 << $bits(reg_addr_t)) - 1];
logic  wr_en;

assign wr_en = i_s3_valid && (i_s3_rd != '0);

// Register file
// --------------------
always_ff @(posedge g_clk) begin
    if (i_rst_n && wr_en) begin
        regs_q[i_s3_rd] <= i_s3_wdata;   // Nothing lands while in reset
    end
end

// Same-cycle write is returned so decode sees the value being retired
function automatic xlen_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
        return '0;
    end
    if (wr_en && (addr == i_s3_rd)) begin
        return i_s3_wdata;
    end
    return regs_q[addr];
endfunction

always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
end

// Trace
// --------------------
assign o_trs_valid = i_s3_valid;
assign o_trs_pc    = i_s3_pc;
assign o_trs_instr = i_s3_instr;
assign o_trs_rd    = i_s3_rd;
assign o_trs_wdata = (i_s3_rd == '0) ? '0 : i_s3_wdata; // x0 writes show zero

endmodule

`default_nettype wire

/* tb/core_clkgen.sv */
/*
 * Testbench clock, 100 ns period, and synchronous reset
 */
`timescale 1ns/1ps
`default_nettype none

module core_clkgen (
    output logic g_clk,
    output logic o_rst_n
);

initial begin
    g_clk = 1'b0;
    forever begin
        #50 g_clk = ~g_clk;              // Half period
    end
end

// Reset low for 5 rising edges
initial begin
    o_rst_n = 1'b0;
    repeat (5) @(posedge g_clk);
    o_rst_n <= 1'b1;                     // Released on the edge
end

endmodule

`default_nettype wire

/* tb/core_properties.sv */
/*
 * Concurrent assertions bound to the core top level
 * Bus hold rule, trace low in reset, one-cycle redirect
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core_properties (
    input wire                  g_clk,
    input wire                  i_rst_n,
    input wire                  i_imem_req,
    input wire [`CORE_XLEN-1:0] i_imem_addr,
    input wire                  i_imem_gnt,
    input wire                  i_trs_valid,
    input wire                  i_cf_valid    // Internal redirect pulse
);

int unsigned fail_count = 0;             // Read by the testbench summary

// Request held with the same address until the grant
a_req_hold: assert property (@(posedge g_clk) disable iff (!i_rst_n)
    (i_imem_req && !i_imem_gnt) |=> (i_imem_req && $stable(i_imem_addr)))
    else begin
        fail_count++;
        $error("Instruction request dropped or address changed before grant");
    end

// Sync reset clears the trace valid on the first reset edge
a_trs_reset: assert property (@(posedge g_clk) !i_rst_n |=> !i_trs_valid)
    else begin
        fail_count++;
        $error("Trace valid high while in reset");
    end

// Redirect lasts a single cycle
a_cf_pulse: assert property (@(posedge g_clk) disable iff (!i_rst_n)
    i_cf_valid |=> !i_cf_valid)
    else begin
        fail_count++;
        $error("Redirect valid held for more than one cycle");
    end

endmodule

bind core_top core_properties u_core_properties (
    .g_clk       (g_clk),
    .i_rst_n     (i_rst_n),
    .i_imem_req  (o_imem_req),
    .i_imem_addr (o_imem_addr),
    .i_imem_gnt  (i_imem_gnt),
    .i_trs_valid (o_trs_valid),
    .i_cf_valid  (cf_valid)
);

`default_nettype wire

/* tb/core_tb.sv */
/*
 * Core testbench: random program in a memory model with random grant delay
 * Architectural reference model, retirement compare process, summary
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core_tb
    import core_types_pkg::*, core_isa_pkg::*;
();

localparam int    NPROG    = 160;                           // Program words
localparam int    MAX_WAIT = 6000;                          // Cycles to reach the end
localparam xlen_t LOOP_PC  = `CORE_PC_RESET + 4 * (NPROG - 1); // Final self loop

logic      g_clk;
logic      rst_n;
logic      imem_req;
xlen_t     imem_addr;
logic      imem_gnt;
instr_t    imem_rdata;
logic      trs_valid;
xlen_t     trs_pc;
instr_t    trs_instr;
reg_addr_t trs_rd;
xlen_t     trs_wdata;

instr_t    prog_mem [0:NPROG-1];
xlen_t     ref_pc;
xlen_t     ref_regs [0:31];                                 // Architectural state
integer    seed = 85;
int        errors = 0;
int        checks = 0;
int        retired = 0;
int        loop_hits = 0;
int        grant_delay;
int        wait_left;
int        cycles;
logic      first_req_seen = 1'b0;
logic      grant_seen = 1'b0;
xlen_t     exp_pc;
instr_t    exp_instr;
reg_addr_t exp_rd;
xlen_t     exp_wdata;
string     tag;

core_clkgen u_core_clkgen (
    .g_clk   (g_clk),
    .o_rst_n (rst_n)
);

core_top u_core_top (
    .g_clk        (g_clk),
    .i_rst_n      (rst_n),
    .o_imem_req   (imem_req),
    .o_imem_addr  (imem_addr),
    .i_imem_gnt   (imem_gnt),
    .i_imem_rdata (imem_rdata),
    .o_trs_valid  (trs_valid),
    .o_trs_pc     (trs_pc),
    .o_trs_instr  (trs_instr),
    .o_trs_rd     (trs_rd),
    .o_trs_wdata  (trs_wdata)
);

// Encoders and program memory
// --------------------
function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
endfunction

function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                 input reg_addr_t rs1, input logic [2:0] f3,
                                 input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                 input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic instr_t enc_j(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic instr_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                 input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic instr_t fetch_word(input xlen_t addr);
    xlen_t offs;
    offs = addr - `CORE_PC_RESET;
    if (addr[1:0] == 2'b00 && addr >= `CORE_PC_RESET && (offs >> 2) < NPROG) begin
        return prog_mem[offs >> 2];
    end
    return ~addr;                        // Fill outside the program
endfunction

task automatic build_program();
    int          idx;
    int          kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    for (idx = 0; idx < 7; idx++) begin
        prog_mem[idx] = enc_i(12'(rand_below(4096)), '0, 3'b000, reg_addr_t'(idx + 1));
    end
    for (idx = 7; idx < NPROG - 1; idx++) begin
        kind = rand_below(10);
        rd   = reg_addr_t'(rand_below(8));                // x0 .. x7 only
        rs1  = reg_addr_t'(rand_below(8));
        rs2  = reg_addr_t'(rand_below(8));
        f3   = 3'(rand_below(8));
        alt  = (rand_below(2) == 1);
        if (kind >= 8 && idx >= NPROG - 5) begin
            kind = 5;                    // Keep targets inside the program
        end
        if (kind < 4) begin
            prog_mem[idx] = enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0,
                                  rs2, rs1, f3, rd);
        end else if (kind < 7) begin
            imm = 12'(rand_below(4096));
            if (f3 == 3'b001) begin
                imm = {7'b0, imm[4:0]};  // SLLI
            end else if (f3 == 3'b101) begin
                imm = {1'b0, alt, 5'b0, imm[4:0]}; // SRLI or SRAI
            end
            prog_mem[idx] = enc_i(imm, rs1, f3, rd);
        end else if (kind == 7) begin
            prog_mem[idx] = {20'(rand_below(1 << 20)), rd, OPC_LUI};
        end else if (kind == 8) begin
            if (alt) begin
                rs2 = rs1;               // Forces BEQ taken, BNE not taken
            end
            prog_mem[idx] = enc_b((rand_below(2) == 1) ? 13'd12 : 13'd8, rs2, rs1,
                                  f3[0] ? 3'b001 : 3'b000);
        end else begin
            prog_mem[idx] = enc_j((rand_below(2) == 1) ? 21'd12 : 21'd8, rd);
        end
    end
    prog_mem[NPROG-1] = enc_j(21'd0, '0); // jal x0, 0
endtask

// Reference model
// --------------------
function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input xlen_t a, input xlen_t b);
    xlen_t res;
    case (f3)
        3'b000: res = alt ? a - b : a + b;
        3'b001: res = a << b[4:0];
        3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: res = (a < b) ? 32'd1 : 32'd0;
        3'b100: res = a ^ b;
        3'b101: begin
            if (alt) begin
                res = $signed(a) >>> b[4:0];
            end else begin
                res = a >> b[4:0];
            end
        end
        3'b110: res = a | b;
        default: res = a & b;
    endcase
    return res;
endfunction

// Executes the instruction at ref_pc, returns what should retire
function automatic void step_reference(output xlen_t pc, output instr_t instr,
                                       output reg_addr_t rd, output xlen_t wdata);
    instr_t     word;
    logic [2:0] f3;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_j;
    xlen_t      result;
    xlen_t      next_pc;
    logic       writes;
    word    = fetch_word(ref_pc);
    f3      = word[14:12];
    a       = ref_regs[word[19:15]];
    b       = ref_regs[word[24:20]];
    imm_i   = {{20{word[31]}}, word[31:20]};
    imm_b   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    imm_j   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    next_pc = ref_pc + 32'd4;
    writes  = 1'b0;
    result  = '0;
    case (word[6:0])
        OPC_OP: begin
            writes = 1'b1;
            result = alu_ref(f3, word[30], a, b);
        end
        OPC_OP_IMM: begin
            writes = 1'b1;
            result = alu_ref(f3, word[30] && (f3 == 3'b101), a, imm_i); // No SUBI
        end
        OPC_LUI: begin
            writes = 1'b1;
            result = {word[31:12], 12'b0};
        end
        OPC_JAL: begin
            writes  = 1'b1;
            result  = ref_pc + 32'd4;    // Link
            next_pc = ref_pc + imm_j;
        end
        OPC_BRANCH: begin
            if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                next_pc = ref_pc + imm_b;
            end
        end
        default: writes = 1'b0;          // Retires without a write
    endcase
    pc    = ref_pc;
    instr = word;
    rd    = writes ? word[11:7] : '0;
    wdata = (rd == '0) ? '0 : result;
    if (rd != '0) begin
        ref_regs[rd] = result;
    end
    ref_pc = next_pc;
endfunction

task automatic check_value(input string name, input xlen_t exp_val, input xlen_t act_val);
    checks++;
    if (act_val !== exp_val) begin
        errors++;
        $display("FAIL %s expected %h actual %h", name, exp_val, act_val);
    end
endtask

// Memory model
// --------------------
always_comb begin
    imem_rdata = fetch_word(imem_addr);  // Data in the grant cycle
end

// Random wait of 0 to 2 cycles per request
always @(posedge g_clk) begin
    if (!rst_n) begin
        imem_gnt  <= 1'b0;
        wait_left <= 0;
    end else if (!imem_req || imem_gnt) begin
        grant_delay = rand_below(3);     // Fresh request next cycle
        imem_gnt  <= (grant_delay == 0);
        wait_left <= grant_delay;
    end else begin
        imem_gnt  <= (wait_left == 1);
        wait_left <= wait_left - 1;
    end
end

// Compare process
// --------------------
always @(negedge g_clk) begin
    if (rst_n) begin
        if (imem_req && !first_req_seen) begin
            first_req_seen = 1'b1;
            check_value("first request address", `CORE_PC_RESET, imem_addr);
        end
        if (trs_valid) begin
            if (!grant_seen) begin
                errors++;
                $display("Instruction retired before the first instruction grant");
            end
            step_reference(exp_pc, exp_instr, exp_rd, exp_wdata);
            tag = $sformatf("retire %0d", retired);
            check_value({tag, " pc"}, exp_pc, trs_pc);
            check_value({tag, " instr"}, exp_instr, trs_instr);
            check_value({tag, " rd"}, xlen_t'(exp_rd), xlen_t'(trs_rd));
            check_value({tag, " wdata"}, exp_wdata, trs_wdata);
            retired++;
            if (exp_pc == LOOP_PC) begin
                loop_hits++;
            end
        end
        if (imem_req && imem_gnt) begin
            grant_seen = 1'b1;
        end
    end
end

// Main sequence
// --------------------
initial begin
    imem_gnt = 1'b0;
    build_program();
    ref_pc = `CORE_PC_RESET;
    foreach (ref_regs[i]) begin
        ref_regs[i] = '0;
    end
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
        @(posedge g_clk);
        cycles++;
    end
    if (rst_n !== 1'b1) begin
        errors++;
        $display("Timeout: reset was never released");
    end else begin
        cycles = 0;
        while (loop_hits < 2 && cycles < MAX_WAIT) begin
            @(posedge g_clk);
            cycles++;
        end
        if (loop_hits < 2) begin
            errors++;
            $display("Timeout: end of program not retired within %0d cycles", MAX_WAIT);
        end
    end
    errors += u_core_top.u_core_properties.fail_count;
    $display("Retired %0d, checks %0d, errors %0d", retired, checks, errors);
    if (errors == 0) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

`default_nettype wire
